/* all.f */
+incdir+testbench
logic/mul_pkg.sv
logic/mul_req_if.sv
logic/mul_wallace_tree.sv
logic/mul_csa_4_2.sv
logic/mul_iterative.sv
logic/mul_op_decode.sv
logic/mul_unit.sv
testbench/mul_unit_tb.sv

/* logic/mul_csa_4_2.sv */
`timescale 1ns/1ps

module mul_csa_4_2 (
  input  logic [mul_pkg::csa_width_lp-1:0] a_i,
  input  logic [mul_pkg::csa_width_lp-1:0] b_i,
  input  logic [mul_pkg::csa_width_lp-1:0] c_i,
  input  logic [mul_pkg::csa_width_lp-1:0] d_i,
  output logic [mul_pkg::csa_width_lp:0]   sum_o,
  output logic [mul_pkg::csa_width_lp:0]   carry_o
);
  import mul_pkg::*;

  logic [csa_width_lp:0] a_x, b_x, c_x, d_x;  // one guard bit each
  logic [csa_width_lp:0] s1, m1, c1;          // first row
  logic [csa_width_lp:0] m2;                  // second row majority

  assign a_x = {1'b0, a_i};
  assign b_x = {1'b0, b_i};
  assign c_x = {1'b0, c_i};
  assign d_x = {1'b0, d_i};

  // row 1 on a, b, c
  assign s1 = a_x ^ b_x ^ c_x;
  assign m1 = (a_x & b_x) | (a_x & c_x) | (b_x & c_x);
  assign c1 = {m1[csa_width_lp-1:0], 1'b0};

  // row 2 on the row 1 sum, d and the intermediate carry
  assign m2      = (s1 & d_x) | (s1 & c1) | (d_x & c1);
  assign sum_o   = s1 ^ d_x ^ c1;
  assign carry_o = {m2[csa_width_lp-1:0], 1'b0};  // bit 0 always clear

endmodule

/* logic/mul_iterative.sv */
`timescale 1ns/1ps

module mul_iterative (
  input  logic                            clk_i,
  input  logic                            reset_internal,
  mul_req_if.core                         req,
  output logic [2*mul_pkg::width_lp-1:0]  product_o,
  output logic                            done_o,
  input  logic                            yumi_i
);
  import mul_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_calc,
    s_adjust,
    s_propagate,
    s_done
  } state_e;

  state_e state_r, state_n;

  logic clear;   // reset or retire
  logic accept;
  logic [iter_cnt_width_lp-1:0] iter_r;
  logic first_iter;
  logic last_iter;

  // operands, multiplier shifts down each calc cycle
  logic [width_lp-1:0] op_a_r;
  logic [width_lp-1:0] op_b_r;
  logic                a_neg_r;
  logic                b_neg_r;
  logic [width_lp-1:0] sign_fix_r;  // correction subtracted from the high word

  // carry-propagate adder
  logic [width_lp-1:0] cpa_a;
  logic [width_lp-1:0] cpa_b;
  logic [width_lp:0]   cpa_sum;

  // carry-save network
  logic [iter_step_lp-1:0][csa_width_lp-1:0] pp;
  logic [csa_width_lp-1:0] tree_sum;
  logic [csa_width_lp-1:0] tree_carry;
  logic [csa_width_lp-1:0] csa_a;
  logic [csa_width_lp-1:0] csa_b;
  logic [csa_width_lp:0]   csa_sum;
  logic [csa_width_lp:0]   csa_carry;

  // low bits waiting for the adder, and the running remnant
  logic [iter_step_lp-1:0] low_sum_r;
  logic [iter_step_lp-1:0] low_carry_r;
  logic [width_lp-1:0]     result_low_r;
  logic [width_lp-1:0]     rem_sum_r;
  logic [width_lp-1:0]     rem_carry_r;

  assign req.ready  = (state_r == s_idle);
  assign accept     = req.valid & req.ready;
  assign clear      = reset_internal | (yumi_i & (state_r == s_done));
  assign first_iter = (iter_r == '0);
  assign last_iter  = (iter_r == iter_cnt_width_lp'(iter_count_lp - 1));

  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle:      if (accept) state_n = s_calc;
      s_calc:      if (last_iter) state_n = s_adjust;
      s_adjust:    state_n = s_propagate;
      s_propagate: state_n = s_done;
      s_done:      state_n = s_done;  // held until yumi
      default:     state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (clear) begin
      state_r <= s_idle;
      iter_r  <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == s_calc) iter_r <= iter_r + 1'b1;  // wraps back to zero
    end
  end

  // partial products from the low multiplier bits
  for (genvar i = 0; i < iter_step_lp; i++) begin : g_pp
    assign pp[i] = csa_width_lp'(op_a_r & {width_lp{op_b_r[i]}}) << i;
  end

  mul_wallace_tree tree (
    .pp_i    (pp),
    .sum_o   (tree_sum),
    .carry_o (tree_carry)
  );

  always_comb begin
    case (state_r)
      s_calc: begin
        csa_a = tree_sum;
        csa_b = tree_carry;
      end
      s_adjust: begin
        // two's complement of the correction
        csa_a = csa_width_lp'(~sign_fix_r);
        csa_b = csa_width_lp'(1'b1);
      end
      default: begin
        csa_a = '0;
        csa_b = '0;
      end
    endcase
  end

  mul_csa_4_2 compress (
    .a_i     (csa_a),
    .b_i     (csa_b),
    .c_i     (csa_width_lp'(rem_sum_r)),
    .d_i     (csa_width_lp'(rem_carry_r)),
    .sum_o   (csa_sum),
    .carry_o (csa_carry)
  );

  always_comb begin
    case (state_r)
      s_calc: begin
        if (first_iter) begin
          // a*b_neg + b*a_neg, the weight of the negative sign bits
          cpa_a = op_a_r & {width_lp{b_neg_r}};
          cpa_b = op_b_r & {width_lp{a_neg_r}};
        end else begin
          cpa_a = width_lp'(low_sum_r);
          cpa_b = width_lp'(low_carry_r);
        end
      end
      s_adjust: begin
        cpa_a = width_lp'(low_sum_r);
        cpa_b = width_lp'(low_carry_r);
      end
      s_propagate: begin
        cpa_a = rem_sum_r;
        cpa_b = rem_carry_r;
      end
      default: begin
        cpa_a = '0;
        cpa_b = '0;
      end
    endcase
  end

  assign cpa_sum = {1'b0, cpa_a} + {1'b0, cpa_b};

  always_ff @(posedge clk_i) begin
    if (clear) begin
      op_a_r       <= '0;
      op_b_r       <= '0;
      a_neg_r      <= 1'b0;
      b_neg_r      <= 1'b0;
      sign_fix_r   <= '0;
      low_sum_r    <= '0;
      low_carry_r  <= '0;
      result_low_r <= '0;
      rem_sum_r    <= '0;
      rem_carry_r  <= '0;
    end else begin
      case (state_r)
        s_idle: begin
          if (accept) begin
            op_a_r  <= req.op_a;
            op_b_r  <= req.op_b;
            a_neg_r <= req.op_a[width_lp-1] & req.a_signed;
            b_neg_r <= req.op_b[width_lp-1] & req.b_signed;
          end
        end
        s_calc: begin
          if (first_iter) sign_fix_r <= cpa_sum[width_lp-1:0];
          op_b_r      <= op_b_r >> iter_step_lp;
          low_sum_r   <= csa_sum[iter_step_lp-1:0];
          // adder carry from the previous low nibble enters at bit 0
          low_carry_r <= {csa_carry[iter_step_lp-1:1], cpa_sum[iter_step_lp] & ~first_iter};
          // first shift-in is the correction and falls off the bottom later
          result_low_r <= {cpa_sum[iter_step_lp-1:0], result_low_r[width_lp-1:iter_step_lp]};
          rem_sum_r    <= csa_sum[csa_width_lp-1:iter_step_lp];
          rem_carry_r  <= csa_carry[csa_width_lp-1:iter_step_lp];
        end
        s_adjust: begin
          result_low_r <= {cpa_sum[iter_step_lp-1:0], result_low_r[width_lp-1:iter_step_lp]};
          rem_sum_r    <= csa_sum[width_lp-1:0];
          rem_carry_r  <= {csa_carry[width_lp-1:1], cpa_sum[iter_step_lp]};
        end
        s_propagate: rem_sum_r <= cpa_sum[width_lp-1:0];  // high word resolved
        default: begin
        end
      endcase
    end
  end

  assign product_o = {rem_sum_r, result_low_r};
  assign done_o    = (state_r == s_done);

endmodule

/* logic/mul_op_decode.sv */
`timescale 1ns/1ps

module mul_op_decode (
  input  logic                            clk_i,
  input  logic                            reset_internal,
  input  logic                            valid_i,
  input  mul_pkg::mul_op_e                op_i,
  input  logic [mul_pkg::width_lp-1:0]    op_a_i,
  input  logic [mul_pkg::width_lp-1:0]    op_b_i,
  mul_req_if.decoder                      req,
  input  logic [2*mul_pkg::width_lp-1:0]  product_i,
  output logic [mul_pkg::width_lp-1:0]    result_o
);
  import mul_pkg::*;

  logic high_half_r;  // selection for the request in flight

  // request passes through to the core
  assign req.valid = valid_i;
  assign req.op_a  = op_a_i;
  assign req.op_b  = op_b_i;

  // signedness per operation
  assign req.a_signed = (op_i == MULH) || (op_i == MULHSU);
  assign req.b_signed = (op_i == MULH);

  always_ff @(posedge clk_i) begin
    if (reset_internal) begin
      high_half_r <= 1'b0;
    end else if (req.valid && req.ready) begin
      high_half_r <= (op_i != MUL);  // captured on accept
    end
  end

  // ready stays low until retirement, so the flag holds through done
  assign result_o = high_half_r ? product_i[2*width_lp-1:width_lp]
                                : product_i[width_lp-1:0];

endmodule

/* logic/mul_pkg.sv */
package mul_pkg;

  // operand width and iteration shape
  localparam int width_lp      = 32;
  localparam int iter_step_lp  = 4;                        // partial products per cycle
  localparam int iter_count_lp = width_lp / iter_step_lp;  // calc cycles per request
  localparam int csa_width_lp  = width_lp + iter_step_lp;

  // iteration counter width
  localparam int iter_cnt_width_lp = $clog2(iter_count_lp);

  // operation select, low half only for MUL
  typedef enum logic [1:0] {
    MUL    = 2'd0,  // low word
    MULH   = 2'd1,  // high word, signed x signed
    MULHSU = 2'd2,  // high word, signed x unsigned
    MULHU  = 2'd3   // high word, unsigned x unsigned
  } mul_op_e;

endpackage

/* logic/mul_req_if.sv */
`timescale 1ns/1ps

interface mul_req_if;
  import mul_pkg::*;

  logic                valid;     // request present
  logic                ready;     // core idle
  logic [width_lp-1:0] op_a;      // multiplicand
  logic [width_lp-1:0] op_b;      // multiplier
  logic                a_signed;
  logic                b_signed;

  // decoder side launches the request
  modport decoder (
    output valid, op_a, op_b, a_signed, b_signed,
    input  ready
  );

  modport core (
    input  valid, op_a, op_b, a_signed, b_signed,
    output ready
  );

endinterface

/* logic/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
  input  logic                          clk_i,
  input  logic                          reset_internal,
  input  logic                          valid_i,
  output logic                          ready_o,
  input  mul_pkg::mul_op_e              op_i,
  input  logic [mul_pkg::width_lp-1:0]  op_a_i,
  input  logic [mul_pkg::width_lp-1:0]  op_b_i,
  output logic [mul_pkg::width_lp-1:0]  result_o,
  output logic                          valid_o,
  input  logic                          yumi_i
);
  import mul_pkg::*;

  mul_req_if req_if ();

  logic [2*width_lp-1:0] product;  // full product from the core

  mul_op_decode decode (
    .clk_i          (clk_i),
    .reset_internal (reset_internal),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .req            (req_if.decoder),
    .product_i      (product),
    .result_o       (result_o)
  );

  mul_iterative core (
    .clk_i          (clk_i),
    .reset_internal (reset_internal),
    .req            (req_if.core),
    .product_o      (product),
    .done_o         (valid_o),
    .yumi_i         (yumi_i)
  );

  assign ready_o = req_if.ready;

endmodule

/* logic/mul_wallace_tree.sv */
`timescale 1ns/1ps

module mul_wallace_tree (
  input  logic [mul_pkg::iter_step_lp-1:0][mul_pkg::csa_width_lp-1:0] pp_i,
  output logic [mul_pkg::csa_width_lp-1:0]                             sum_o,
  output logic [mul_pkg::csa_width_lp-1:0]                             carry_o
);
  import mul_pkg::*;

  // first layer of full adders
  logic [csa_width_lp-1:0] l1_sum;
  logic [csa_width_lp-1:0] l1_maj;
  logic [csa_width_lp-1:0] l1_carry;

  // second layer
  logic [csa_width_lp-1:0] l2_sum;
  logic [csa_width_lp-1:0] l2_maj;
  logic [csa_width_lp-1:0] l2_carry;

  // layer 1 takes the three lowest weighted partial products
  assign l1_sum = pp_i[0] ^ pp_i[1] ^ pp_i[2];
  assign l1_maj = (pp_i[0] & pp_i[1])
                | (pp_i[0] & pp_i[2])
                | (pp_i[1] & pp_i[2]);

  // carries weigh one place higher
  assign l1_carry = {l1_maj[csa_width_lp-2:0], 1'b0};

  // layer 2 folds in the last partial product
  assign l2_sum = l1_sum ^ l1_carry ^ pp_i[3];
  assign l2_maj = (l1_sum & l1_carry)
                | (l1_sum & pp_i[3])
                | (l1_carry & pp_i[3]);
  assign l2_carry = {l2_maj[csa_width_lp-2:0], 1'b0};

  // the four products sum below 2**csa_width, so no top carry is lost
  assign sum_o   = l2_sum;
  assign carry_o = l2_carry;

endmodule

/* testbench/mul_ref.svh */
`ifndef MUL_REF_SVH
`define MUL_REF_SVH

// extend both operands to 64 bits, multiply, pick the word
function automatic logic [31:0] mul_ref(input mul_pkg::mul_op_e op,
                                        input logic [31:0]      a,
                                        input logic [31:0]      b);
  logic [63:0] a_x;
  logic [63:0] b_x;
  logic [63:0] prod;
  a_x = {32'b0, a};
  b_x = {32'b0, b};
  if (op == mul_pkg::MULH || op == mul_pkg::MULHSU) a_x[63:32] = {32{a[31]}};
  if (op == mul_pkg::MULH) b_x[63:32] = {32{b[31]}};
  prod = a_x * b_x;  // low 64 bits exact for any signedness
  return (op == mul_pkg::MUL) ? prod[31:0] : prod[63:32];
endfunction

`endif

/* testbench/mul_unit_tb.sv */
`timescale 1ns/1ps

module mul_unit_tb;
  import mul_pkg::*;

  `include "mul_ref.svh"

  typedef struct packed {
    mul_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
  } req_t;

  localparam int n_dir_lp   = 100;
  localparam int n_rand_lp  = 200;
  localparam int n_bp_lp    = 40;
  localparam int timeout_lp = (n_dir_lp + n_rand_lp + n_bp_lp) * 40 + 500;

  logic                clk_i, reset_internal, valid_i, ready_o, valid_o, yumi_i;
  mul_op_e             op_i;
  logic [width_lp-1:0] op_a_i, op_b_i, result_o;

  logic [31:0] corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
  req_t        exp_q [$];   // expected results in accept order
  int          wait_q [$];  // yumi delays for the back-pressure test
  int          seed, pass_count, fail_count, lat_count, lat_fails;
  logic        yumi_always;

  mul_unit UUT (
    .clk_i(clk_i), .reset_internal(reset_internal), .valid_i(valid_i), .ready_o(ready_o),
    .op_i(op_i), .op_a_i(op_a_i), .op_b_i(op_b_i), .result_o(result_o), .valid_o(valid_o),
    .yumi_i(yumi_i)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic issue(input mul_op_e op, input logic [31:0] a, input logic [31:0] b);
    req_t r;
    @(negedge clk_i);
    valid_i = 1'b1;
    op_i    = op;
    op_a_i  = a;
    op_b_i  = b;
    while (!ready_o) @(negedge clk_i);  // held until the core is idle
    r.op  = op;
    r.a   = a;
    r.b   = b;
    r.exp = mul_ref(op, a, b);
    exp_q.push_back(r);
    @(posedge clk_i);  // accept edge
  endtask

  task automatic finish_test(input string name, input int n, input int fails_before);
    @(negedge clk_i);
    valid_i = 1'b0;
    while (exp_q.size() != 0 || valid_o) @(negedge clk_i);
    $display("%s: %0d requests, %0d failures", name, n, fail_count - fails_before);
  endtask

  // yumi either held high or withheld for a queued number of cycles
  always @(negedge clk_i) begin : yumi_drive
    int wait_left;
    if (reset_internal) yumi_i = 1'b0;
    else if (yumi_always) yumi_i = 1'b1;
    else if (valid_o && !yumi_i) begin
      if (wait_left < 0) wait_left = (wait_q.size() != 0) ? wait_q.pop_front() : 0;
      if (wait_left == 0) yumi_i = 1'b1;
      else wait_left--;
    end else begin
      yumi_i    = 1'b0;
      wait_left = -1;  // next result loads a fresh delay
    end
  end

  // compare process, sees pre-edge values
  always @(posedge clk_i) begin : compare
    req_t cur;
    int   edge_idx, accept_idx;
    logic in_flight, retired_prev, valid_prev;
    logic [31:0] held;
    if (reset_internal) begin
      in_flight    = 1'b0;
      retired_prev = 1'b0;
      valid_prev   = 1'b0;
    end else begin
      edge_idx++;
      if (retired_prev && (!ready_o || valid_o)) begin
        $display("ready_o and valid_o did not return to idle the cycle after yumi_i");
        fail_count++;
      end
      if (in_flight && ready_o) begin
        $display("ready_o went high while a request was in flight");
        fail_count++;
      end
      if (valid_prev && !retired_prev && !valid_o) begin
        $display("valid_o dropped before yumi_i retired the result");
        fail_count++;
      end
      if (valid_prev && !retired_prev && valid_o && result_o !== held) begin
        $display("[FAIL] result_o = %h changed while held, was %h", result_o, held);
        fail_count++;
      end
      if (valid_o && !valid_prev) begin
        lat_count++;
        if (edge_idx - accept_idx != 11) begin  // rose on edge accept + 10
          $display("valid_o rose %0d cycles after accept instead of 10",
                   edge_idx - accept_idx - 1);
          fail_count++;
          lat_fails++;
        end
      end
      retired_prev = valid_o && yumi_i;
      if (valid_o && yumi_i) begin
        in_flight = 1'b0;
        if (exp_q.size() == 0) begin
          $display("a result was retired with no request outstanding");
          fail_count++;
        end else begin
          cur = exp_q.pop_front();
          if (result_o !== cur.exp) begin
            $display("[FAIL] result_o = %h expected %h (op %h a %h b %h)",
                     result_o, cur.exp, cur.op, cur.a, cur.b);
            fail_count++;
          end else pass_count++;
        end
      end
      if (valid_i && ready_o) begin
        in_flight  = 1'b1;
        accept_idx = edge_idx;
      end
      valid_prev = valid_o;
      held       = result_o;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < timeout_lp) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("the run timed out after %0d cycles", timeout_lp);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    int          fails_before;
    logic [1:0]  op_bits;
    seed           = 32'h8dca_2fe0;
    reset_internal = 1'b1;
    valid_i        = 1'b0;
    op_i           = MUL;
    op_a_i         = '0;
    op_b_i         = '0;
    yumi_i         = 1'b0;
    yumi_always    = 1'b1;
    repeat (16) @(negedge clk_i);
    reset_internal = 1'b0;

    fails_before = fail_count;
    if (ready_o !== 1'b1 || valid_o !== 1'b0) begin
      $display("[FAIL] ready_o = %h valid_o = %h after reset, expected 1 and 0",
               ready_o, valid_o);
      fail_count++;
    end
    $display("reset: %0d failures", fail_count - fails_before);

    fails_before = fail_count;
    for (int op = 0; op < 4; op++)
      for (int i = 0; i < 5; i++)
        for (int j = 0; j < 5; j++) issue(mul_op_e'(op), corners[i], corners[j]);
    finish_test("directed corners", n_dir_lp, fails_before);

    fails_before = fail_count;
    for (int i = 0; i < n_rand_lp; i++) begin
      op_bits = $random(seed);
      issue(mul_op_e'(op_bits), $random(seed), $random(seed));
    end
    finish_test("random operands", n_rand_lp, fails_before);

    fails_before = fail_count;
    for (int i = 0; i < n_bp_lp; i++) wait_q.push_back($unsigned($random(seed)) % 21);
    yumi_always = 1'b0;  // changed while idle
    for (int i = 0; i < n_bp_lp; i++) begin
      op_bits = $random(seed);
      issue(mul_op_e'(op_bits), $random(seed), $random(seed));
    end
    finish_test("back-pressure", n_bp_lp, fails_before);
    $display("latency: %0d results measured, %0d failures", lat_count, lat_fails);

    $display("results passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count == n_dir_lp + n_rand_lp + n_bp_lp)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule
